// File: common/ctrl_pkg.sv
////////////////////////////////////////////////////////////
// controller types for the in-order core
// machine mode only, no user level and no debug states
// cause values follow the RISC-V mcause layout
////////////////////////////////////////////////////////////

package ctrl_pkg;

  // controller FSM states, 11 of 16 codes used
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    WAIT_SLEEP,
    FIRST_FETCH,
    DECODE,
    IRQ_TAKEN_ID,
    IRQ_TAKEN_IF,
    IRQ_FLUSH,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

  // next pc source in the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd2,
    PC_BRANCH    = 3'd3,
    PC_EXCEPTION = 3'd4,
    PC_ERET      = 3'd5
  } pc_mux_e;

  // offset into the trap vector table
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'd0,
    EXC_PC_ECALL   = 2'd1,
    EXC_PC_IRQ     = 2'd3
  } exc_pc_e;

  // interrupt line number from the interrupt controller
  typedef logic [4:0] irq_id_t;

  // bit 5 set for interrupts, low bits hold the code
  typedef logic [5:0] cause_t;

  localparam cause_t CAUSE_ILLEGAL = 6'd2;
  localparam cause_t CAUSE_ECALL_M = 6'd11;

  // one-hot decoder flags for the instruction in ID
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic ebrk;
    logic pipe_flush;
    logic load_event;
  } dec_flags_t;

  // pc update request towards the prefetcher
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    exc_pc_e exc_pc_mux;
  } pc_ctrl_t;

  // CSR save and restore strobes plus causes
  typedef struct packed {
    logic   save_if;
    logic   save_id;
    logic   save_cause;
    logic   restore_mret;
    cause_t cause;
    cause_t exc_cause;
    logic   irq_ack;
    logic   exc_ack;
  } trap_ctrl_t;

endpackage

// File: common/hazard_pkg.sv
////////////////////////////////////////////////////////////
// hazard and forwarding types shared by the ID stage
// match bits come from register index compares outside
////////////////////////////////////////////////////////////

package hazard_pkg;

  // operand mux select in the ID stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'd0,
    SEL_FW_EX   = 2'd1,
    SEL_FW_WB   = 2'd2
  } fwd_sel_e;

  // one bit per source operand
  // set when a stage's destination equals that source
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } op_match_t;

  // jump class as reported by the decoder
  typedef enum logic [1:0] {
    NONE = 2'd0,
    JAL  = 2'd1,
    JALR = 2'd2,
    COND = 2'd3
  } jump_kind_e;

  // register file write enables seen by ID
  typedef struct packed {
    // load/store result in EX
    logic ex;
    // result in WB
    logic wb;
    // ALU or MUL result forwarded from EX
    logic alu;
  } we_fw_t;

endpackage

// File: ctrl_fsm/ctrl_fsm.sv
////////////////////////////////////////////////////////////
// main controller FSM: boot, sleep, decode, flush, traps
// machine mode interrupts only, gated by m_ie_i
// decoder flags must stay valid in ID until FLUSH_WB
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_fsm
(
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   fetch_enable_i,
  input  logic                   instr_valid_i,
  input  logic                   id_ready_i,
  input  logic                   ex_valid_i,

  input  ctrl_pkg::dec_flags_t   dec_i,
  input  hazard_pkg::jump_kind_e jump_dec_i,
  input  hazard_pkg::jump_kind_e jump_id_i,
  input  logic                   branch_taken_ex_i,

  input  logic                   irq_req_i,
  input  ctrl_pkg::irq_id_t      irq_id_i,
  input  logic                   m_ie_i,

  input  logic                   jr_stall_i,

  output logic                   is_decoding_o,
  output logic                   ctrl_busy_o,
  output logic                   first_fetch_o,
  output logic                   instr_req_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o,
  output logic                   exc_kill_o,
  output ctrl_pkg::pc_ctrl_t     pc_o,
  output ctrl_pkg::trap_ctrl_t   trap_o
);

  import ctrl_pkg::*;
  import hazard_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // set once the boot pc has been issued
  logic boot_done;
  logic boot_done_q;
  // a jump in ID already redirected the pc
  logic jump_done;
  logic jump_done_q;

  logic irq_enable;
  logic jump_in_dec;
  logic branch_in_id;
  logic trap_insn;

  // interrupt request that the core may take now
  assign irq_enable   = irq_req_i & m_ie_i;
  assign jump_in_dec  = (jump_dec_i == JAL) || (jump_dec_i == JALR);
  // a conditional branch in ID resolves in EX next cycle
  assign branch_in_id = (jump_id_i == COND);
  // every flag that needs the pipeline drained first
  assign trap_insn    = dec_i.illegal | dec_i.ecall | dec_i.mret |
                        dec_i.ebrk | dec_i.pipe_flush;

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    // defaults, fetching and busy
    state_d       = state_q;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_kill_o    = 1'b0;
    boot_done     = 1'b0;
    jump_done     = jump_done_q;

    pc_o.pc_set     = 1'b0;
    pc_o.pc_mux     = PC_BOOT;
    pc_o.exc_pc_mux = EXC_PC_IRQ;

    trap_o.save_if      = 1'b0;
    trap_o.save_id      = 1'b0;
    trap_o.save_cause   = 1'b0;
    trap_o.restore_mret = 1'b0;
    trap_o.cause        = '0;
    trap_o.exc_cause    = '0;
    trap_o.irq_ack      = 1'b0;
    trap_o.exc_ack      = 1'b0;

    case (state_q)
      // idle after reset until fetch is enabled
      RESET:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_enable_i)
        begin
          state_d = BOOT_SET;
        end
      end

      // load the boot address, single cycle
      BOOT_SET:
      begin
        pc_o.pc_set = 1'b1;
        pc_o.pc_mux = PC_BOOT;
        boot_done   = 1'b1;
        state_d     = FIRST_FETCH;
      end

      // one cycle to let the flush settle before sleeping
      WAIT_SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // clock may be gated outside, wake on enable or irq
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i || irq_req_i)
        begin
          state_d = FIRST_FETCH;
        end
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
        begin
          state_d = DECODE;
        end
        // pipeline is empty here, so take the irq straight from IF
        if (irq_enable)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN_IF;
        end
      end

      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // taken branch in EX wins, ID content is discarded
          pc_o.pc_set = 1'b1;
          pc_o.pc_mux = PC_BRANCH;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          // hold the irq while a branch in ID still has to resolve
          if (irq_enable && !branch_in_id)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = IRQ_FLUSH;
          end
          else
          begin
            // kill the EX result if an irq is pending
            exc_kill_o = irq_req_i;
            if (jump_in_dec)
            begin
              // target known in ID, redirect once
              pc_o.pc_mux = PC_JUMP;
              if (!jr_stall_i && !jump_done_q)
              begin
                pc_o.pc_set = 1'b1;
                jump_done   = 1'b1;
              end
            end
            else if (trap_insn)
            begin
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              state_d   = FLUSH_EX;
            end
            else if (dec_i.load_event)
            begin
              // event load blocks fetch while it waits in ID
              halt_if_o = 1'b1;
            end
          end
        end
      end

      // drain EX, latency set by ex_valid_i
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
        begin
          state_d = FLUSH_WB;
        end
      end

      // irq may have dropped or been masked meanwhile
      IRQ_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (irq_enable)
        begin
          state_d = IRQ_TAKEN_ID;
        end
        else
        begin
          state_d = DECODE;
        end
      end

      // both entries share the vector, only the saved pc differs
      IRQ_TAKEN_ID, IRQ_TAKEN_IF:
      begin
        pc_o.pc_set      = 1'b1;
        pc_o.pc_mux      = PC_EXCEPTION;
        pc_o.exc_pc_mux  = EXC_PC_IRQ;
        trap_o.exc_cause = {1'b0, irq_id_i};
        trap_o.cause     = {1'b1, irq_id_i};
        trap_o.save_cause = 1'b1;
        trap_o.save_id   = (state_q == IRQ_TAKEN_ID);
        trap_o.save_if   = (state_q == IRQ_TAKEN_IF);
        trap_o.irq_ack   = 1'b1;
        trap_o.exc_ack   = 1'b1;
        state_d          = DECODE;
      end

      // pipeline empty, issue the trap redirect
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (dec_i.ecall)
        begin
          pc_o.pc_set       = 1'b1;
          pc_o.pc_mux       = PC_EXCEPTION;
          pc_o.exc_pc_mux   = EXC_PC_ECALL;
          trap_o.save_id    = 1'b1;
          trap_o.save_cause = 1'b1;
          trap_o.exc_cause  = CAUSE_ECALL_M;
          trap_o.cause      = CAUSE_ECALL_M;
        end
        else if (dec_i.illegal)
        begin
          pc_o.pc_set       = 1'b1;
          pc_o.pc_mux       = PC_EXCEPTION;
          pc_o.exc_pc_mux   = EXC_PC_ILLINSN;
          trap_o.save_id    = 1'b1;
          trap_o.save_cause = 1'b1;
          trap_o.exc_cause  = CAUSE_ILLEGAL;
          trap_o.cause      = CAUSE_ILLEGAL;
        end
        else if (dec_i.mret)
        begin
          pc_o.pc_set         = 1'b1;
          pc_o.pc_mux         = PC_ERET;
          trap_o.restore_mret = 1'b1;
        end
        // ebreak and pipe flush just resume

        if (fetch_enable_i)
        begin
          state_d = DECODE;
        end
        else
        begin
          state_d = WAIT_SLEEP;
        end
      end

      // unused codes: resume if booted, else restart
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = boot_done_q ? DECODE : RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      boot_done_q <= 1'b0;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // sticky once set
      boot_done_q <= boot_done_q | boot_done;
      // cleared when ID accepts the next instruction
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

// File: hdl/hazard_unit.sv
////////////////////////////////////////////////////////////
// load-use and jump-register stall detection
// purely combinational, match bits are already qualified
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hazard_unit
(
  input  logic                   is_decoding_i,
  input  logic                   illegal_i,
  input  logic                   data_req_ex_i,
  input  hazard_pkg::jump_kind_e jump_dec_i,
  input  hazard_pkg::we_fw_t     we_i,
  input  hazard_pkg::op_match_t  match_ex_i,
  input  hazard_pkg::op_match_t  match_wb_i,
  input  hazard_pkg::op_match_t  match_alu_i,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   deassert_we_o
);

  import hazard_pkg::*;

  logic ex_uses_src;
  logic jalr_dep;

  // load in EX writes a register that ID reads
  assign ex_uses_src = match_ex_i.a | match_ex_i.b | match_ex_i.c;

  // jalr base (operand a) still in flight somewhere
  assign jalr_dep = (we_i.wb  & match_wb_i.a)  |
                    (we_i.ex  & match_ex_i.a)  |
                    (we_i.alu & match_alu_i.a);

  always_comb
  begin
    load_stall_o = data_req_ex_i & we_i.ex & ex_uses_src;

    // no forwarding path into the pc adder, so always stall
    jr_stall_o = (jump_dec_i == JALR) & jalr_dep;

    // stalled or non-decoding cycles must not write back
    deassert_we_o = ~is_decoding_i | illegal_i | load_stall_o | jr_stall_o;
  end

endmodule

// File: hdl/fwd_unit.sv
////////////////////////////////////////////////////////////
// operand forwarding selects for operands a, b and c
// EX result takes priority over WB
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fwd_unit
(
  input  hazard_pkg::we_fw_t    we_i,
  input  hazard_pkg::op_match_t match_wb_i,
  input  hazard_pkg::op_match_t match_alu_i,
  output hazard_pkg::fwd_sel_e  fwd_a_o,
  output hazard_pkg::fwd_sel_e  fwd_b_o,
  output hazard_pkg::fwd_sel_e  fwd_c_o
);

  import hazard_pkg::*;

  // same rule for every operand
  function automatic fwd_sel_e pick_src(input logic alu_hit, input logic wb_hit);
    fwd_sel_e sel;
    if (alu_hit)
      sel = SEL_FW_EX;
    else if (wb_hit)
      sel = SEL_FW_WB;
    else
      sel = SEL_REGFILE;
    return sel;
  endfunction

  always_comb
  begin
    // the younger EX result shadows WB
    fwd_a_o = pick_src(we_i.alu & match_alu_i.a, we_i.wb & match_wb_i.a);
    fwd_b_o = pick_src(we_i.alu & match_alu_i.b, we_i.wb & match_wb_i.b);
    fwd_c_o = pick_src(we_i.alu & match_alu_i.c, we_i.wb & match_wb_i.c);
  end

endmodule

// File: hdl/ctrl_top.sv
////////////////////////////////////////////////////////////
// controller top: FSM plus hazard and forwarding units
// all outputs are plain strobes or levels, no handshakes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ctrl_top
(
  input  logic                   clk,
  input  logic                   rst_n,

  // core control
  input  logic                   fetch_enable_i,
  input  logic                   instr_valid_i,
  input  logic                   id_ready_i,
  input  logic                   ex_valid_i,

  // decoder and branch unit
  input  ctrl_pkg::dec_flags_t   dec_i,
  input  hazard_pkg::jump_kind_e jump_dec_i,
  input  hazard_pkg::jump_kind_e jump_id_i,
  input  logic                   branch_taken_ex_i,

  // interrupt controller
  input  logic                   irq_req_i,
  input  ctrl_pkg::irq_id_t      irq_id_i,
  input  logic                   m_ie_i,

  // LSU and register file compares
  input  logic                   data_req_ex_i,
  input  hazard_pkg::we_fw_t     we_i,
  input  hazard_pkg::op_match_t  match_ex_i,
  input  hazard_pkg::op_match_t  match_wb_i,
  input  hazard_pkg::op_match_t  match_alu_i,

  output logic                   ctrl_busy_o,
  output logic                   first_fetch_o,
  output logic                   is_decoding_o,
  output logic                   instr_req_o,
  output logic                   halt_if_o,
  output logic                   halt_id_o,
  output logic                   exc_kill_o,
  output ctrl_pkg::pc_ctrl_t     pc_o,
  output ctrl_pkg::trap_ctrl_t   trap_o,

  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   deassert_we_o,

  output hazard_pkg::fwd_sel_e   fwd_a_o,
  output hazard_pkg::fwd_sel_e   fwd_b_o,
  output hazard_pkg::fwd_sel_e   fwd_c_o
);

  // FSM reads jr_stall_o back, hazard unit reads is_decoding_o
  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .dec_i             (dec_i),
    .jump_dec_i        (jump_dec_i),
    .jump_id_i         (jump_id_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .irq_req_i         (irq_req_i),
    .irq_id_i          (irq_id_i),
    .m_ie_i            (m_ie_i),
    .jr_stall_i        (jr_stall_o),
    .is_decoding_o     (is_decoding_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .first_fetch_o     (first_fetch_o),
    .instr_req_o       (instr_req_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .exc_kill_o        (exc_kill_o),
    .pc_o              (pc_o),
    .trap_o            (trap_o)
  );

  hazard_unit u_hazard_unit (
    .is_decoding_i (is_decoding_o),
    .illegal_i     (dec_i.illegal),
    .data_req_ex_i (data_req_ex_i),
    .jump_dec_i    (jump_dec_i),
    .we_i          (we_i),
    .match_ex_i    (match_ex_i),
    .match_wb_i    (match_wb_i),
    .match_alu_i   (match_alu_i),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o),
    .deassert_we_o (deassert_we_o)
  );

  // independent of the FSM
  fwd_unit u_fwd_unit (
    .we_i        (we_i),
    .match_wb_i  (match_wb_i),
    .match_alu_i (match_alu_i),
    .fwd_a_o     (fwd_a_o),
    .fwd_b_o     (fwd_b_o),
    .fwd_c_o     (fwd_c_o)
  );

endmodule

// File: bench/tb_ctrl_checks.sv
////////////////////////////////////////////////////////////
// checker placed beside the DUT, samples on the falling edge
// stall rules only valid while the tb holds the FSM in DECODE
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ctrl_checks
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [1:0]             mode_i,
  input  hazard_pkg::we_fw_t     we_i,
  input  hazard_pkg::op_match_t  match_ex_i,
  input  hazard_pkg::op_match_t  match_wb_i,
  input  hazard_pkg::op_match_t  match_alu_i,
  input  logic                   data_req_ex_i,
  input  logic                   instr_valid_i,
  input  logic                   illegal_i,
  input  hazard_pkg::jump_kind_e jump_dec_i,
  input  logic                   m_ie_i,
  input  ctrl_pkg::irq_id_t      irq_id_i,
  input  hazard_pkg::fwd_sel_e   fwd_a_i,
  input  hazard_pkg::fwd_sel_e   fwd_b_i,
  input  hazard_pkg::fwd_sel_e   fwd_c_i,
  input  logic                   is_decoding_i,
  input  logic                   load_stall_i,
  input  logic                   jr_stall_i,
  input  logic                   deassert_we_i,
  input  ctrl_pkg::pc_ctrl_t     pc_i,
  input  ctrl_pkg::trap_ctrl_t   trap_i
);

  import ctrl_pkg::*;
  import hazard_pkg::*;

  localparam logic [1:0] MODE_FWD   = 2'd1;
  localparam logic [1:0] MODE_STALL = 2'd2;

  int fail_cnt  = 0;
  int check_cnt = 0;

  fwd_sel_e exp_a;
  fwd_sel_e exp_b;
  fwd_sel_e exp_c;
  logic     exp_ld;
  logic     exp_jr;
  logic     exp_dwe;

  // EX beats WB, regfile when no stage hits
  function automatic fwd_sel_e expect_sel(input logic alu_hit, input logic wb_hit);
    return alu_hit ? SEL_FW_EX : (wb_hit ? SEL_FW_WB : SEL_REGFILE);
  endfunction

  task automatic compare(input string name, input int exp, input int act);
    check_cnt++;
    assert (exp == act)
    else
    begin
      $display("mismatch %s expected %0d actual %0d", name, exp, act);
      fail_cnt++;
    end
  endtask

  assign exp_a = expect_sel(we_i.alu & match_alu_i.a, we_i.wb & match_wb_i.a);
  assign exp_b = expect_sel(we_i.alu & match_alu_i.b, we_i.wb & match_wb_i.b);
  assign exp_c = expect_sel(we_i.alu & match_alu_i.c, we_i.wb & match_wb_i.c);

  // load in EX feeding any operand
  assign exp_ld = data_req_ex_i && we_i.ex && (match_ex_i != 3'b000);
  // jalr base still pending in WB, EX or the ALU path
  assign exp_jr = (jump_dec_i == JALR) &&
                  ((we_i.wb && match_wb_i.a) || (we_i.ex && match_ex_i.a) ||
                   (we_i.alu && match_alu_i.a));
  // FSM sits in DECODE, so decoding equals instr_valid
  assign exp_dwe = !instr_valid_i || illegal_i || exp_ld || exp_jr;

  always @(negedge clk)
  begin
    if (rst_n && mode_i == MODE_FWD)
    begin
      compare("forwarding fwd_a", exp_a, fwd_a_i);
      compare("forwarding fwd_b", exp_b, fwd_b_i);
      compare("forwarding fwd_c", exp_c, fwd_c_i);
    end
    if (rst_n && mode_i == MODE_STALL)
    begin
      compare("stalls is_decoding", instr_valid_i, is_decoding_i);
      compare("stalls load_stall", exp_ld, load_stall_i);
      compare("stalls jr_stall", exp_jr, jr_stall_i);
      compare("stalls deassert_we", exp_dwe, deassert_we_i);
    end
    // any ack must be an enabled irq redirected to the vector
    if (rst_n && trap_i.irq_ack)
    begin
      compare("interrupts m_ie at ack", 1, m_ie_i);
      compare("interrupts pc_set", 1, pc_i.pc_set);
      compare("interrupts pc_mux", PC_EXCEPTION, pc_i.pc_mux);
      compare("interrupts cause", {1'b1, irq_id_i}, trap_i.cause);
      compare("interrupts exc_cause", {1'b0, irq_id_i}, trap_i.exc_cause);
      compare("interrupts exc_ack", 1, trap_i.exc_ack);
    end
  end

endmodule

// File: bench/tb_ctrl_top.sv
////////////////////////////////////////////////////////////
// testbench for the controller top level
// inputs change on the rising edge, checks on the falling one
// any wait gives up after 50 cycles and ends the run
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ctrl_top;

  import ctrl_pkg::*;
  import hazard_pkg::*;

  localparam int         TIMEOUT    = 50;
  localparam logic [1:0] MODE_FWD   = 2'd1;
  localparam logic [1:0] MODE_STALL = 2'd2;
  localparam int SIG_PC_SET = 0;
  localparam int SIG_FIRST  = 1;
  localparam int SIG_HALT   = 2;
  localparam int SIG_ACK    = 3;
  localparam int SIG_BUSY   = 4;

  logic clk = 1'b0;
  logic rst_n;
  logic fetch_enable;
  logic instr_valid;
  logic id_ready;
  logic ex_valid;
  dec_flags_t dec;
  jump_kind_e jump_dec;
  jump_kind_e jump_id;
  logic branch_taken;
  logic irq_req;
  irq_id_t irq_id;
  logic m_ie;
  logic data_req;
  we_fw_t we;
  op_match_t match_ex;
  op_match_t match_wb;
  op_match_t match_alu;
  logic [1:0] check_mode;

  logic ctrl_busy;
  logic first_fetch;
  logic is_decoding;
  logic instr_req;
  logic halt_if;
  logic halt_id;
  logic exc_kill;
  pc_ctrl_t pc;
  trap_ctrl_t trap;
  logic load_stall;
  logic jr_stall;
  logic deassert_we;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;
  fwd_sel_e fwd_c;

  logic [15:0] lfsr = 16'd7863;
  int tb_fail = 0;
  int tb_checks = 0;
  int errs_before = 0;
  string cur_test;

  always #5 clk = ~clk;

  ctrl_top dut (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .instr_valid_i (instr_valid),
    .id_ready_i (id_ready), .ex_valid_i (ex_valid),
    .dec_i (dec), .jump_dec_i (jump_dec), .jump_id_i (jump_id),
    .branch_taken_ex_i (branch_taken),
    .irq_req_i (irq_req), .irq_id_i (irq_id), .m_ie_i (m_ie),
    .data_req_ex_i (data_req), .we_i (we),
    .match_ex_i (match_ex), .match_wb_i (match_wb), .match_alu_i (match_alu),
    .ctrl_busy_o (ctrl_busy), .first_fetch_o (first_fetch),
    .is_decoding_o (is_decoding), .instr_req_o (instr_req),
    .halt_if_o (halt_if), .halt_id_o (halt_id), .exc_kill_o (exc_kill),
    .pc_o (pc), .trap_o (trap),
    .load_stall_o (load_stall), .jr_stall_o (jr_stall), .deassert_we_o (deassert_we),
    .fwd_a_o (fwd_a), .fwd_b_o (fwd_b), .fwd_c_o (fwd_c)
  );

  tb_ctrl_checks checks (
    .clk (clk), .rst_n (rst_n), .mode_i (check_mode),
    .we_i (we), .match_ex_i (match_ex), .match_wb_i (match_wb),
    .match_alu_i (match_alu), .data_req_ex_i (data_req),
    .instr_valid_i (instr_valid), .illegal_i (dec.illegal),
    .jump_dec_i (jump_dec), .m_ie_i (m_ie), .irq_id_i (irq_id),
    .fwd_a_i (fwd_a), .fwd_b_i (fwd_b), .fwd_c_i (fwd_c),
    .is_decoding_i (is_decoding),
    .load_stall_i (load_stall), .jr_stall_i (jr_stall),
    .deassert_we_i (deassert_we), .pc_i (pc), .trap_i (trap)
  );

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function logic lfsr_step();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[6:0], lfsr_step()};
    return v;
  endfunction

  function automatic logic probe(input int which);
    case (which)
      SIG_PC_SET: probe = pc.pc_set;
      SIG_FIRST:  probe = first_fetch;
      SIG_HALT:   probe = halt_id;
      SIG_ACK:    probe = trap.irq_ack;
      default:    probe = ctrl_busy;
    endcase
  endfunction

  task automatic check_value(input string name, input int exp, input int act);
    tb_checks++;
    assert (exp == act)
    else
    begin
      $display("mismatch %s %s expected %0d actual %0d", cur_test, name, exp, act);
      tb_fail++;
    end
  endtask

  // polls on falling edges, cycles counts edges seen
  task automatic wait_on(input int which, input logic level, input string what,
                         output int cycles);
    cycles = 0;
    do
    begin
      @(negedge clk);
      cycles++;
    end
    while (probe(which) != level && cycles < TIMEOUT);
    if (probe(which) != level)
    begin
      $display("timeout in %s after %0d cycles waiting for %s", cur_test, TIMEOUT, what);
      $display("*** TEST FAILED ***");
      $finish;
    end
  endtask

  task automatic end_test();
    int now_errs;
    now_errs = tb_fail + checks.fail_cnt;
    $display("test %s done, %0d errors", cur_test, now_errs - errs_before);
    errs_before = now_errs;
  endtask

  task automatic boot_from_reset();
    int cycles;
    cur_test = "reset_boot";
    @(negedge clk);
    check_value("busy after reset", 0, ctrl_busy);
    check_value("instr_req after reset", 0, instr_req);
    @(posedge clk);
    fetch_enable <= 1'b1;
    wait_on(SIG_PC_SET, 1'b1, "boot pc_set", cycles);
    check_value("boot cycle", 2, cycles);
    check_value("boot pc_mux", PC_BOOT, pc.pc_mux);
    @(negedge clk);
    check_value("pc_set one cycle", 0, pc.pc_set);
    check_value("first_fetch", 1, first_fetch);
    // let ID accept, FSM moves on to DECODE
    @(posedge clk);
    id_ready <= 1'b1;
    wait_on(SIG_FIRST, 1'b0, "decode entry", cycles);
    end_test();
  endtask

  task automatic sweep_forwarding();
    cur_test = "forwarding";
    for (int i = 0; i < 200; i++)
    begin
      @(posedge clk);
      check_mode <= MODE_FWD;
      we        <= we_fw_t'(rand_bits(3));
      match_wb  <= op_match_t'(rand_bits(3));
      match_alu <= op_match_t'(rand_bits(3));
    end
    @(posedge clk);
    check_mode <= 2'd0;
    end_test();
  endtask

  task automatic sweep_stalls();
    logic iv;
    cur_test = "stalls";
    for (int i = 0; i < 200; i++)
    begin
      @(posedge clk);
      iv = rand_bits(1) != 0;
      check_mode  <= MODE_STALL;
      instr_valid <= iv;
      // illegal only while idle, else the FSM leaves DECODE
      dec.illegal <= !iv && (rand_bits(1) != 0);
      data_req    <= rand_bits(1) != 0;
      jump_dec    <= jump_kind_e'(rand_bits(2));
      we          <= we_fw_t'(rand_bits(3));
      match_ex    <= op_match_t'(rand_bits(3));
      match_wb    <= op_match_t'(rand_bits(3));
      match_alu   <= op_match_t'(rand_bits(3));
    end
    @(posedge clk);
    check_mode  <= 2'd0;
    instr_valid <= 1'b0;
    dec         <= '0;
    data_req    <= 1'b0;
    jump_dec    <= NONE;
    we          <= '0;
    end_test();
  endtask

  task automatic take_trap(input string name, input dec_flags_t flags,
                           input pc_mux_e exp_mux, input cause_t exp_cause);
    int cycles;
    int delay;
    cur_test = name;
    @(posedge clk);
    dec         <= flags;
    instr_valid <= 1'b1;
    wait_on(SIG_HALT, 1'b1, "flush start", cycles);
    // trap flag decoded this cycle, write-back blocked only when illegal
    check_value("is_decoding", 1, is_decoding);
    check_value("deassert_we", flags.illegal, deassert_we);
    @(posedge clk);
    instr_valid <= 1'b0;
    delay = rand_bits(3);
    repeat (delay) @(posedge clk);
    ex_valid <= 1'b1;
    wait_on(SIG_PC_SET, 1'b1, "trap pc_set", cycles);
    check_value("pc_mux", exp_mux, pc.pc_mux);
    check_value("restore_mret", flags.mret, trap.restore_mret);
    if (!flags.mret)
    begin
      check_value("cause", exp_cause, trap.cause);
      check_value("exc_cause", exp_cause, trap.exc_cause);
      check_value("save_id", 1, trap.save_id);
    end
    @(posedge clk);
    dec      <= '0;
    ex_valid <= 1'b0;
    end_test();
  endtask

  task automatic take_interrupts();
    int cycles;
    int acks;
    int kills;
    cur_test = "interrupts";
    @(posedge clk);
    irq_req     <= 1'b1;
    m_ie        <= 1'b1;
    irq_id      <= irq_id_t'(rand_bits(5));
    instr_valid <= 1'b1;
    wait_on(SIG_ACK, 1'b1, "irq_ack", cycles);
    @(posedge clk);
    irq_req     <= 1'b0;
    // masked request must never be acknowledged
    @(posedge clk);
    irq_req <= 1'b1;
    m_ie    <= 1'b0;
    acks = 0;
    kills = 0;
    repeat (TIMEOUT)
    begin
      @(negedge clk);
      acks += trap.irq_ack;
      // pending irq while decoding kills the EX result
      kills += exc_kill;
    end
    check_value("masked acks", 0, acks);
    check_value("exc_kill while pending", TIMEOUT, kills);
    @(posedge clk);
    irq_req     <= 1'b0;
    instr_valid <= 1'b0;
    end_test();
  endtask

  task automatic sleep_and_wake();
    int cycles;
    cur_test = "sleep_wake";
    @(posedge clk);
    fetch_enable <= 1'b0;
    dec.ebrk     <= 1'b1;
    instr_valid  <= 1'b1;
    wait_on(SIG_HALT, 1'b1, "flush start", cycles);
    @(posedge clk);
    instr_valid <= 1'b0;
    ex_valid    <= 1'b1;
    wait_on(SIG_BUSY, 1'b0, "sleep entry", cycles);
    check_value("halt_if asleep", 1, halt_if);
    check_value("halt_id asleep", 1, halt_id);
    @(posedge clk);
    dec      <= '0;
    ex_valid <= 1'b0;
    irq_req  <= 1'b1;
    wait_on(SIG_FIRST, 1'b1, "wake to first fetch", cycles);
    @(posedge clk);
    irq_req      <= 1'b0;
    fetch_enable <= 1'b1;
    end_test();
  endtask

  initial
  begin
    int errors;
    rst_n        = 1'b0;
    fetch_enable = 1'b0;
    instr_valid  = 1'b0;
    id_ready     = 1'b0;
    ex_valid     = 1'b0;
    dec          = '0;
    jump_dec     = NONE;
    jump_id      = NONE;
    branch_taken = 1'b0;
    irq_req      = 1'b0;
    irq_id       = '0;
    m_ie         = 1'b0;
    data_req     = 1'b0;
    we           = '0;
    match_ex     = '0;
    match_wb     = '0;
    match_alu    = '0;
    check_mode   = 2'd0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    boot_from_reset();
    sweep_forwarding();
    sweep_stalls();
    take_trap("trap_illegal", 6'b100000, PC_EXCEPTION, CAUSE_ILLEGAL);
    take_trap("trap_ecall", 6'b010000, PC_EXCEPTION, CAUSE_ECALL_M);
    take_trap("trap_mret", 6'b001000, PC_ERET, '0);
    take_interrupts();
    sleep_and_wake();

    errors = tb_fail + checks.fail_cnt;
    $display("%0d checks, %0d errors", tb_checks + checks.check_cnt, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: src.f
common/ctrl_pkg.sv
common/hazard_pkg.sv
ctrl_fsm/ctrl_fsm.sv
hdl/hazard_unit.sv
hdl/fwd_unit.sv
hdl/ctrl_top.sv
bench/tb_ctrl_checks.sv
bench/tb_ctrl_top.sv
